//--- mc_cache_pkg.sv
package mc_cache_pkg;

    // Line geometry seen by both caches
    localparam int LINE_BITS   = 256;
    localparam int OFFSET_BITS = 5;
    localparam int ADDR_BITS   = 32;
    localparam int TAG_BITS    = ADDR_BITS - OFFSET_BITS;

    typedef logic [LINE_BITS-1:0] line_t;
    typedef logic [TAG_BITS-1:0]  tag_t;

    // Instruction cache only ever reads
    typedef struct packed {
        logic [ADDR_BITS-1:0] addr;
        logic                 read;
    } icache_req_t;

    typedef struct packed {
        logic [ADDR_BITS-1:0] addr;
        logic                 read;
        logic                 write;
        line_t                wdata;
    } dcache_req_t;

    typedef struct packed {
        line_t rdata;
        logic  resp;
    } cache_resp_t;

    typedef enum logic {port_i, port_d} port_e;

endpackage : mc_cache_pkg

//--- mc_dram_pkg.sv
package mc_dram_pkg;

    // Tag and byte offset view of a line address
    typedef struct packed {
        mc_cache_pkg::tag_t                          tag;
        logic [mc_cache_pkg::OFFSET_BITS-1:0]        offset;
    } line_addr_s;

    // Raw byte address or tag/offset split of the same word
    typedef union packed {
        logic [mc_cache_pkg::ADDR_BITS-1:0] raw;
        line_addr_s                         f;
    } line_addr_u;

    typedef struct packed {
        line_addr_u          addr;
        logic                read;
        logic                write;
        mc_cache_pkg::line_t wdata;
    } dram_req_t;

    // One cycle pulse from the adapter, responses may arrive out of order
    typedef struct packed {
        line_addr_u          raddr;
        mc_cache_pkg::line_t rdata;
        logic                resp;
    } dram_resp_t;

endpackage : mc_dram_pkg

//--- mc_port_ctrl.sv
`timescale 1ns/100ps

module mc_port_ctrl (
    input  logic clk,
    input  logic rst,

    input  logic icache_read,
    input  logic dcache_read,
    input  logic dcache_write,

    input  logic cl_ready,
    input  logic match_i,
    input  logic match_d,

    output logic issue_i,
    output logic issue_d,
    output logic read_issue_d,

    output logic icache_resp_valid,
    output logic dcache_resp_valid
);

    // Instruction port never enters s_write
    typedef enum logic [1:0] {
        s_idle,
        s_issue,
        s_await,
        s_write
    } port_state_e;

    port_state_e i_state;
    port_state_e d_state;

    logic d_wants;

    always_comb begin
        d_wants = (d_state == s_issue) || (d_state == s_write);

        // Instruction port goes first whenever both are ready to issue
        issue_i = (i_state == s_issue) && cl_ready;
        issue_d = d_wants && cl_ready && !issue_i;

        read_issue_d = issue_d && (d_state == s_issue);

        // Reads answer from the registered response, writes answer on issue
        icache_resp_valid = (i_state == s_await) && match_i;
        dcache_resp_valid = ((d_state == s_await) && match_d)
                          || (issue_d && (d_state == s_write));
    end

    // Instruction port FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            i_state <= s_idle;
        end else begin
            unique case (i_state)
                s_idle: begin
                    if (icache_read) begin
                        i_state <= s_issue;
                    end
                end
                s_issue: begin
                    if (issue_i) begin
                        i_state <= s_await;
                    end
                end
                s_await: begin
                    if (icache_resp_valid) begin
                        i_state <= s_idle;
                    end
                end
                default: begin
                    i_state <= s_idle;
                end
            endcase
        end
    end

    // Data port FSM, a read takes precedence if the cache raises both
    always_ff @(posedge clk) begin
        if (rst) begin
            d_state <= s_idle;
        end else begin
            unique case (d_state)
                s_idle: begin
                    if (dcache_read) begin
                        d_state <= s_issue;
                    end else if (dcache_write) begin
                        d_state <= s_write;
                    end
                end
                s_issue: begin
                    if (issue_d) begin
                        d_state <= s_await;
                    end
                end
                s_await: begin
                    if (dcache_resp_valid) begin
                        d_state <= s_idle;
                    end
                end
                s_write: begin
                    if (issue_d) begin
                        d_state <= s_idle;
                    end
                end
            endcase
        end
    end

    // One request on the adapter port per cycle, data waits behind instruction
    a_single_issue: assert property (@(posedge clk) disable iff (rst)
        (i_state == s_issue && d_wants) |=> d_state == $past(d_state));

    // Adapter back-pressure holds every pending request
    a_issue_needs_ready: assert property (@(posedge clk) disable iff (rst)
        !cl_ready |=> ($past(i_state) != s_issue || i_state == s_issue)
                   && (!$past(d_wants) || d_state == $past(d_state)));

endmodule : mc_port_ctrl

//--- dram_resp_capture.sv
`timescale 1ns/100ps

module dram_resp_capture (
    input  logic                    clk,
    input  logic                    rst,

    input  mc_dram_pkg::dram_resp_t dram_resp,
    input  logic                    issue_i,
    input  logic                    read_issue_d,
    input  mc_dram_pkg::line_addr_u icache_addr,
    input  mc_dram_pkg::line_addr_u dcache_addr,

    output logic                    match_i,
    output logic                    match_d,
    output mc_cache_pkg::line_t     resp_line
);

    // Tag each port is waiting on
    mc_cache_pkg::tag_t pend_tag_i;
    mc_cache_pkg::tag_t pend_tag_d;

    logic               resp_valid_q;
    mc_cache_pkg::tag_t resp_tag_q;

    always_ff @(posedge clk) begin
        if (issue_i) begin
            pend_tag_i <= icache_addr.f.tag;
        end
        if (read_issue_d) begin
            pend_tag_d <= dcache_addr.f.tag;
        end
    end

    // Response valid is a one cycle copy of the adapter pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= dram_resp.resp;
        end
    end

    always_ff @(posedge clk) begin
        if (dram_resp.resp) begin
            resp_tag_q <= dram_resp.raddr.f.tag;
            resp_line  <= dram_resp.rdata;
        end
    end

    assign match_i = resp_valid_q && (resp_tag_q == pend_tag_i);
    assign match_d = resp_valid_q && (resp_tag_q == pend_tag_d);

    // Only one port latches a pending tag per cycle
    a_single_tag_load: assert property (@(posedge clk) disable iff (rst)
        !(issue_i && read_issue_d));

endmodule : dram_resp_capture

//--- dram_route.sv
`timescale 1ns/100ps

module dram_route (
    input  mc_cache_pkg::icache_req_t icache_req,
    input  mc_cache_pkg::dcache_req_t dcache_req,
    input  logic                      issue_i,
    input  logic                      issue_d,
    input  mc_cache_pkg::line_t       resp_line,

    output mc_dram_pkg::dram_req_t    dram_req,
    output mc_cache_pkg::line_t       icache_rdata,
    output mc_cache_pkg::line_t       dcache_rdata
);

    mc_cache_pkg::port_e sel;

    // Address follows the granted port, instruction side by default
    assign sel = issue_d ? mc_cache_pkg::port_d : mc_cache_pkg::port_i;

    always_comb begin
        if (sel == mc_cache_pkg::port_d) begin
            dram_req.addr.raw = dcache_req.addr;
        end else begin
            dram_req.addr.raw = icache_req.addr;
        end

        // Cache holds its request steady, so its flags tell read from write
        dram_req.read  = issue_i || (issue_d && dcache_req.read);
        dram_req.write = issue_d && dcache_req.write && !dcache_req.read;
        dram_req.wdata = dcache_req.wdata;

        // Write requests come from the data port alone and never overlap a read
        if (dram_req.write) begin
            assert (issue_d && !issue_i && !dram_req.read)
            else $error("DRAM write without a data port write grant");
        end
    end

    // Registered line goes to both caches, resp decides who takes it
    assign icache_rdata = resp_line;
    assign dcache_rdata = resp_line;

endmodule : dram_route

//--- memory_controller.sv
`timescale 1ns/100ps

module memory_controller (
    input  logic                      clk,
    input  logic                      rst,

    input  mc_cache_pkg::icache_req_t icache_req,
    input  mc_cache_pkg::dcache_req_t dcache_req,
    output mc_cache_pkg::cache_resp_t icache_resp,
    output mc_cache_pkg::cache_resp_t dcache_resp,

    input  logic                      cl_ready,
    input  mc_dram_pkg::dram_resp_t   dram_resp,
    output mc_dram_pkg::dram_req_t    dram_req
);

    logic issue_i;
    logic issue_d;
    logic read_issue_d;
    logic match_i;
    logic match_d;
    logic icache_resp_valid;
    logic dcache_resp_valid;

    mc_cache_pkg::line_t     resp_line;
    mc_cache_pkg::line_t     icache_rdata;
    mc_cache_pkg::line_t     dcache_rdata;
    mc_dram_pkg::line_addr_u icache_addr;
    mc_dram_pkg::line_addr_u dcache_addr;

    assign icache_addr.raw = icache_req.addr;
    assign dcache_addr.raw = dcache_req.addr;

    mc_port_ctrl u_port_ctrl (
        .clk               (clk),
        .rst               (rst),
        .icache_read       (icache_req.read),
        .dcache_read       (dcache_req.read),
        .dcache_write      (dcache_req.write),
        .cl_ready          (cl_ready),
        .match_i           (match_i),
        .match_d           (match_d),
        .issue_i           (issue_i),
        .issue_d           (issue_d),
        .read_issue_d      (read_issue_d),
        .icache_resp_valid (icache_resp_valid),
        .dcache_resp_valid (dcache_resp_valid)
    );

    dram_resp_capture u_resp_capture (
        .clk          (clk),
        .rst          (rst),
        .dram_resp    (dram_resp),
        .issue_i      (issue_i),
        .read_issue_d (read_issue_d),
        .icache_addr  (icache_addr),
        .dcache_addr  (dcache_addr),
        .match_i      (match_i),
        .match_d      (match_d),
        .resp_line    (resp_line)
    );

    dram_route u_route (
        .icache_req   (icache_req),
        .dcache_req   (dcache_req),
        .issue_i      (issue_i),
        .issue_d      (issue_d),
        .resp_line    (resp_line),
        .dram_req     (dram_req),
        .icache_rdata (icache_rdata),
        .dcache_rdata (dcache_rdata)
    );

    assign icache_resp = '{rdata: icache_rdata, resp: icache_resp_valid};
    assign dcache_resp = '{rdata: dcache_rdata, resp: dcache_resp_valid};

endmodule : memory_controller

//--- tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset held for 8 rising edges, released just after the edge
    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
    end

endmodule : tb_clock_gen

//--- tb_memory_controller.sv
`timescale 1ns/100ps

module tb_memory_controller;

    localparam int          TIMEOUT = 200;
    localparam logic [31:0] MIX     = 32'h5a3c_96e1;

    logic                      clk;
    logic                      rst;
    logic                      cl_ready;
    mc_cache_pkg::icache_req_t icache_req;
    mc_cache_pkg::dcache_req_t dcache_req;
    mc_cache_pkg::cache_resp_t icache_resp;
    mc_cache_pkg::cache_resp_t dcache_resp;
    mc_dram_pkg::dram_resp_t   dram_resp;
    mc_dram_pkg::dram_req_t    dram_req;

    int          seed;
    int          err_count;
    int          test_count;
    bit          auto_resp;
    bit          i_fwd;
    logic [31:0] req_q[$];

    tb_clock_gen u_clock_gen (.clk(clk), .rst(rst));

    memory_controller UUT (.*);

    // Line contents the DRAM model holds for a tag
    function automatic mc_cache_pkg::line_t model_line(input mc_cache_pkg::tag_t tag);
        return {8{5'b0, tag}} ^ {8{MIX}};
    endfunction

    task automatic report_value(input string sig, input logic [255:0] got,
                                input logic [255:0] exp);
        $display("Error: %s is %0h, expected %0h", sig, got, exp);
        err_count++;
    endtask

    task automatic report_failure(input string what);
        $display("Failure: %s", what);
        err_count++;
    endtask

    task automatic finish_test(input string name);
        test_count++;
        $display("Test %0d (%s) done, %0d errors so far", test_count, name, err_count);
    endtask

    // Called just after a rising edge, pulses the adapter response for one cycle
    task automatic send_resp(input logic [31:0] addr);
        dram_resp.raddr.raw = addr;
        dram_resp.rdata     = model_line(addr[31:5]);
        dram_resp.resp      = 1'b1;
        @(posedge clk);
        #2;
        dram_resp.resp = 1'b0;
    endtask

    task automatic icache_read(input logic [31:0] addr);
        int n;
        icache_req.addr = addr;
        icache_req.read = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!icache_resp.resp && n < TIMEOUT);
        if (!icache_resp.resp) begin
            report_failure("instruction read got no response in time");
        end
        @(posedge clk);
        #2;
        icache_req.read = 1'b0;
    endtask

    task automatic dcache_access(input logic [31:0] addr, input bit is_write);
        int n;
        dcache_req.addr  = addr;
        dcache_req.wdata = {4{addr, ~addr}};
        dcache_req.read  = !is_write;
        dcache_req.write = is_write;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!dcache_resp.resp && n < TIMEOUT);
        if (!dcache_resp.resp) begin
            report_failure("data access got no response in time");
        end
        @(posedge clk);
        #2;
        dcache_req.read  = 1'b0;
        dcache_req.write = 1'b0;
    endtask

    task automatic wait_requests(input int count);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            #2;
            n++;
        end while (req_q.size() < count && n < TIMEOUT);
        if (req_q.size() < count) begin
            report_failure("DRAM reads were not issued in time");
        end
    endtask

    // DRAM model samples requests mid-cycle
    always @(negedge clk) begin
        if (dram_req.read && cl_ready) begin
            req_q.push_back(dram_req.addr.raw);
        end
        if (!icache_req.read) begin
            i_fwd <= 1'b0;
        end else if (dram_req.read && cl_ready && dram_req.addr.raw == icache_req.addr) begin
            i_fwd <= 1'b1;
        end
    end

    // Answers queued reads in order after a random gap
    initial begin : dram_model
        int gap;
        forever begin
            @(posedge clk);
            #2;
            if (auto_resp && req_q.size() > 0) begin
                gap = 1 + ($unsigned($random(seed)) % 4);
                repeat (gap) begin
                    @(posedge clk);
                    #2;
                end
                send_resp(req_q.pop_front());
            end
        end
    end

    a_reset_quiet: assert property (@(posedge clk) $fell(rst) |->
        !dram_req.read && !dram_req.write && !icache_resp.resp && !dcache_resp.resp)
        else report_failure("outputs active right after reset");
    a_ready_hold: assert property (@(posedge clk) disable iff (rst)
        !cl_ready |-> !dram_req.read && !dram_req.write)
        else report_failure("DRAM request sent while cl_ready was low");
    a_read_addr: assert property (@(posedge clk) disable iff (rst)
        dram_req.read |-> (icache_req.read && dram_req.addr.raw == icache_req.addr)
                       || (dcache_req.read && dram_req.addr.raw == dcache_req.addr))
        else report_failure("DRAM read at an address no cache is reading");
    a_i_first: assert property (@(posedge clk) disable iff (rst)
        (dram_req.read && dcache_req.read && dram_req.addr.raw == dcache_req.addr
         && icache_req.read && $past(icache_req.read)) |-> i_fwd)
        else report_failure("data read went to DRAM ahead of a waiting instruction read");
    a_write_addr: assert property (@(posedge clk) disable iff (rst)
        dram_req.write |-> dram_req.addr.raw == dcache_req.addr)
        else report_value("dram_req.addr", $sampled(dram_req.addr.raw),
                          $sampled(dcache_req.addr));
    a_write_data: assert property (@(posedge clk) disable iff (rst)
        dram_req.write |-> dram_req.wdata == dcache_req.wdata)
        else report_value("dram_req.wdata", $sampled(dram_req.wdata),
                          $sampled(dcache_req.wdata));
    a_write_ack: assert property (@(posedge clk) disable iff (rst)
        dram_req.write |-> dcache_req.write && dcache_resp.resp)
        else report_failure("DRAM write without a data cache write answered that cycle");
    a_iresp_data: assert property (@(posedge clk) disable iff (rst)
        icache_resp.resp |-> icache_resp.rdata == model_line(icache_req.addr[31:5]))
        else report_value("icache_resp.rdata", $sampled(icache_resp.rdata),
                          model_line($sampled(icache_req.addr[31:5])));
    a_iresp_time: assert property (@(posedge clk) disable iff (rst)
        icache_resp.resp |-> icache_req.read && $past(dram_resp.resp)
                          && $past(dram_resp.raddr.f.tag) == icache_req.addr[31:5])
        else report_failure("icache resp not one cycle after its own DRAM response");
    a_dresp_data: assert property (@(posedge clk) disable iff (rst)
        dcache_resp.resp && dcache_req.read |->
            dcache_resp.rdata == model_line(dcache_req.addr[31:5]))
        else report_value("dcache_resp.rdata", $sampled(dcache_resp.rdata),
                          model_line($sampled(dcache_req.addr[31:5])));
    a_dresp_time: assert property (@(posedge clk) disable iff (rst)
        dcache_resp.resp |-> (dcache_req.write ? dram_req.write
            : (dcache_req.read && $past(dram_resp.resp)
               && $past(dram_resp.raddr.f.tag) == dcache_req.addr[31:5])))
        else report_failure("dcache resp without its own write issue or DRAM response");

    initial begin : stimulus
        int n;
        icache_req = '0;
        dcache_req = '0;
        dram_resp  = '0;
        cl_ready   = 1'b1;
        auto_resp  = 1'b1;
        seed       = 32'h3bc0_c3be;
        err_count  = 0;
        test_count = 0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (rst && n < TIMEOUT);
        @(posedge clk);
        #2;

        icache_read(32'h0000_1240);
        finish_test("instruction read");

        dcache_access(32'h0000_8a60, 1'b1);
        finish_test("data write");

        fork
            icache_read(32'h0001_0000);
            dcache_access(32'h0002_0020, 1'b0);
        join
        finish_test("instruction first");

        cl_ready = 1'b0;
        fork
            icache_read(32'h0003_3300);
            dcache_access(32'h0004_4400, 1'b1);
            begin
                repeat (6) @(posedge clk);
                #2;
                cl_ready = 1'b1;
            end
        join
        finish_test("back-pressure");

        // Responses from here on are sent by hand
        auto_resp = 1'b0;
        fork
            icache_read(32'h0005_5500);
            dcache_access(32'h0006_6600, 1'b0);
            begin
                wait_requests(2);
                if (req_q.size() == 2) begin
                    send_resp(req_q[1]);
                    send_resp(req_q[0]);
                end
                req_q.delete();
            end
        join
        finish_test("reverse order");

        fork
            icache_read(32'h0007_7700);
            begin
                wait_requests(1);
                send_resp(32'h0bad_0000);
                repeat (2) @(posedge clk);
                #2;
                if (req_q.size() == 1) begin
                    send_resp(req_q.pop_front());
                end
            end
        join
        send_resp(32'h0bad_1000);
        repeat (4) @(posedge clk);
        finish_test("unmatched response");

        $display("%0d tests run, %0d errors", test_count, err_count);
        if (err_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule : tb_memory_controller

//--- all.f
mc_cache_pkg.sv
mc_dram_pkg.sv
mc_port_ctrl.sv
dram_resp_capture.sv
dram_route.sv
memory_controller.sv
tb_clock_gen.sv
tb_memory_controller.sv

//--- run.sh
#!/bin/sh
# Build and run the memory controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_memory_controller -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1
